//--- build.f
vertex_pkg.sv
sync_fifo.sv
vertex_read_sequencer.sv
vertex_line_buffer.sv
vertex_job_control.sv
tb_memory_model.sv
tb_vertex_job_control.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_vertex_job_control
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= *** TEST PASSED ***

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

//--- tb_vertex_job_control.sv
// Testbench for the vertex job controller: random arrays, random back-pressure, model-based checks
`timescale 1ns/1ps
`default_nettype none

module tb_vertex_job_control import vertex_pkg::*; ();

	localparam int          NUM_VERTICES = 100;
	localparam int          NUM_WORDS    = 128;
	localparam int          NUM_CMDS     = 12;
	localparam int          TIMEOUT      = 20000;
	localparam logic [31:0] SEED         = 32'he6094038;

	logic                      clock = 1'b0;
	logic                      rstn;
	logic                      wed_valid;
	logic [VERTEX_BITS-1:0]    wed_num_vertices;
	logic [ADDR_BITS-1:0]      wed_in_degree_addr;
	logic [ADDR_BITS-1:0]      wed_out_degree_addr;
	logic [ADDR_BITS-1:0]      wed_edges_idx_addr;
	logic                      cmd_valid;
	logic [ADDR_BITS-1:0]      cmd_addr;
	array_t                    cmd_array;
	logic [COUNT_BITS-1:0]     cmd_count;
	logic                      cmd_alfull;
	logic                      data_valid;
	array_t                    data_array;
	logic [COUNT_BITS-1:0]     data_count;
	logic [CACHELINE_BITS-1:0] data_line;
	logic                      vertex_request;
	logic                      vertex_valid;
	logic [VERTEX_BITS-1:0]    vertex_id;
	logic [VERTEX_BITS-1:0]    vertex_in_degree;
	logic [VERTEX_BITS-1:0]    vertex_out_degree;
	logic [VERTEX_BITS-1:0]    vertex_edges_idx;
	logic                      vertex_empty;
	logic [VERTEX_BITS-1:0]    vertex_job_counter;
	logic [VERTEX_BITS-1:0]    edge_job_counter;

	logic [VERTEX_BITS-1:0]    in_words [NUM_WORDS];
	logic [VERTEX_BITS-1:0]    out_words [NUM_WORDS];
	logic [VERTEX_BITS-1:0]    edges_words [NUM_WORDS];
	logic [ADDR_BITS-1:0]      in_base;
	logic [ADDR_BITS-1:0]      out_base;
	logic [ADDR_BITS-1:0]      edges_base;
	logic [VERTEX_BITS-1:0]    edge_sum;
	int                        cmd_seen;
	int                        jobs_seen;
	int                        mismatches;
	int                        failures;
	int                        consumer_mode;
	logic                      timed_out;

	always #4 clock = ~clock;

	vertex_job_control #(.JOB_FIFO_DEPTH(64), .CMD_FIFO_DEPTH(16)) uut (
		.clock(clock), .rstn(rstn),
		.wed_valid(wed_valid), .wed_num_vertices(wed_num_vertices),
		.wed_in_degree_addr(wed_in_degree_addr), .wed_out_degree_addr(wed_out_degree_addr),
		.wed_edges_idx_addr(wed_edges_idx_addr),
		.cmd_valid(cmd_valid), .cmd_addr(cmd_addr), .cmd_array(cmd_array),
		.cmd_count(cmd_count), .cmd_alfull(cmd_alfull),
		.data_valid(data_valid), .data_array(data_array),
		.data_count(data_count), .data_line(data_line),
		.vertex_request(vertex_request), .vertex_valid(vertex_valid), .vertex_id(vertex_id),
		.vertex_in_degree(vertex_in_degree), .vertex_out_degree(vertex_out_degree),
		.vertex_edges_idx(vertex_edges_idx), .vertex_empty(vertex_empty),
		.vertex_job_counter(vertex_job_counter), .edge_job_counter(edge_job_counter)
	);

	tb_memory_model #(.NUM_WORDS(NUM_WORDS)) u_memory (
		.clock(clock), .rstn(rstn),
		.cmd_valid(cmd_valid), .cmd_addr(cmd_addr), .cmd_array(cmd_array),
		.cmd_count(cmd_count),
		.in_base(in_base), .out_base(out_base), .edges_base(edges_base),
		.in_words(in_words), .out_words(out_words), .edges_words(edges_words),
		.cmd_alfull(cmd_alfull), .data_valid(data_valid), .data_array(data_array),
		.data_count(data_count), .data_line(data_line)
	);

	// Reverse byte order, one byte at a time
	function automatic logic [VERTEX_BITS-1:0] swap_word(input logic [VERTEX_BITS-1:0] word);
		logic [VERTEX_BITS-1:0] result;
		for (int b = 0; b < 4; b++)
			result[8*b +: 8] = word[8*(3-b) +: 8];
		return result;
	endfunction

	function automatic logic [ADDR_BITS-1:0] base_of(input int arr);
		if (arr == 0)
			return in_base;
		else if (arr == 1)
			return out_base;
		return edges_base;
	endfunction

	task automatic report_mismatch(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		mismatches++;
		$display("mismatch %s: expected %h actual %h", name, expected, actual);
	endtask

	//////////////////////////////
	// Per-cycle output checks
	//////////////////////////////
	task automatic monitor_outputs();
		int                    line;
		int                    arr;
		int                    rem;
		logic [ADDR_BITS-1:0]  exp_addr;
		logic [COUNT_BITS-1:0] exp_count;
		if (cmd_valid) begin
			if (cmd_seen >= NUM_CMDS) begin
				failures++;
				$display("error: read command beyond the expected %0d", NUM_CMDS);
			end else begin
				line      = cmd_seen / 3;
				arr       = cmd_seen % 3;
				rem       = NUM_VERTICES - line * LINE_VERTICES;
				exp_addr  = base_of(arr) + ADDR_BITS'(line * CACHELINE_BYTES);
				exp_count = COUNT_BITS'((rem > LINE_VERTICES) ? LINE_VERTICES : rem);
				if (64'(cmd_array) !== 64'(arr))
					report_mismatch("cmd_array", 64'(arr), 64'(cmd_array));
				if (cmd_addr !== exp_addr)
					report_mismatch("cmd_addr", exp_addr, cmd_addr);
				if (cmd_count !== exp_count)
					report_mismatch("cmd_count", 64'(exp_count), 64'(cmd_count));
			end
			cmd_seen++;
		end
		if (vertex_valid) begin
			// vertex_request still holds the value seen at this edge
			if (!vertex_request) begin
				failures++;
				$display("error: vertex_valid without a preceding vertex_request");
			end
			if (jobs_seen >= NUM_VERTICES) begin
				failures++;
				$display("error: vertex job beyond the expected %0d", NUM_VERTICES);
			end else begin
				if (vertex_id !== VERTEX_BITS'(jobs_seen))
					report_mismatch("vertex_id", 64'(jobs_seen), 64'(vertex_id));
				if (vertex_in_degree !== swap_word(in_words[jobs_seen]))
					report_mismatch("vertex_in_degree", 64'(swap_word(in_words[jobs_seen])),
						64'(vertex_in_degree));
				if (vertex_out_degree !== swap_word(out_words[jobs_seen]))
					report_mismatch("vertex_out_degree", 64'(swap_word(out_words[jobs_seen])),
						64'(vertex_out_degree));
				if (vertex_edges_idx !== swap_word(edges_words[jobs_seen]))
					report_mismatch("vertex_edges_idx", 64'(swap_word(edges_words[jobs_seen])),
						64'(vertex_edges_idx));
			end
			jobs_seen++;
		end
	endtask

	task automatic drive_consumer();
		case (consumer_mode)
			1:       vertex_request = ($urandom_range(1, 0) == 1) && !vertex_empty;
			2:       vertex_request = !vertex_empty;
			default: vertex_request = 1'b0;
		endcase
	endtask

	task automatic step_cycle();
		@(posedge clock);
		#1;
		monitor_outputs();
		drive_consumer();
	endtask

	initial begin
		int cycles;
		void'($urandom(SEED));
		rstn                = 1'b0;
		wed_valid           = 1'b0;
		wed_num_vertices    = '0;
		wed_in_degree_addr  = '0;
		wed_out_degree_addr = '0;
		wed_edges_idx_addr  = '0;
		vertex_request      = 1'b0;
		cmd_seen            = 0;
		jobs_seen           = 0;
		mismatches          = 0;
		failures            = 0;
		consumer_mode       = 0;
		timed_out           = 1'b0;
		for (int i = 0; i < NUM_WORDS; i++) begin
			in_words[i]    = $urandom;
			out_words[i]   = $urandom;
			edges_words[i] = $urandom;
		end
		in_base    = {$urandom, $urandom} & ~64'h7f;
		out_base   = {$urandom, $urandom} & ~64'h7f;
		edges_base = {$urandom, $urandom} & ~64'h7f;
		edge_sum   = '0;
		for (int i = 0; i < NUM_VERTICES; i++)
			edge_sum = edge_sum + swap_word(out_words[i]);

		repeat (10) @(posedge clock);
		#1;
		rstn = 1'b1;

		// Quiet outputs before the work descriptor
		repeat (20) begin
			step_cycle();
			if (cmd_valid || vertex_valid) begin
				failures++;
				$display("error: output strobe before the work descriptor");
			end
			if (vertex_empty !== 1'b1)
				report_mismatch("idle_vertex_empty", 64'd1, 64'(vertex_empty));
			if (vertex_job_counter !== '0)
				report_mismatch("idle_vertex_job_counter", 64'd0, 64'(vertex_job_counter));
			if (edge_job_counter !== '0)
				report_mismatch("idle_edge_job_counter", 64'd0, 64'(edge_job_counter));
		end

		wed_valid           = 1'b1;
		wed_num_vertices    = VERTEX_BITS'(NUM_VERTICES);
		wed_in_degree_addr  = in_base;
		wed_out_degree_addr = out_base;
		wed_edges_idx_addr  = edges_base;

		// Random consumer for the first jobs
		consumer_mode = 1;
		cycles        = 0;
		while (jobs_seen < 40 && cycles < TIMEOUT) begin
			step_cycle();
			cycles++;
		end
		if (jobs_seen < 40) begin
			timed_out = 1'b1;
			failures++;
			$display("error: timed out waiting for the first 40 vertex jobs");
		end

		// Stalled consumer, then drain
		if (!timed_out) begin
			consumer_mode = 0;
			repeat (200) step_cycle();
			consumer_mode = 2;
			cycles        = 0;
			while (jobs_seen < NUM_VERTICES && cycles < TIMEOUT) begin
				step_cycle();
				cycles++;
			end
			if (jobs_seen < NUM_VERTICES) begin
				timed_out = 1'b1;
				failures++;
				$display("error: timed out draining vertex jobs, %0d received", jobs_seen);
			end
		end

		if (!timed_out) begin
			if (vertex_job_counter !== VERTEX_BITS'(NUM_VERTICES))
				report_mismatch("vertex_job_counter", 64'(NUM_VERTICES), 64'(vertex_job_counter));
			if (edge_job_counter !== edge_sum)
				report_mismatch("edge_job_counter", 64'(edge_sum), 64'(edge_job_counter));
			// Settle window for stray commands or jobs
			repeat (20) step_cycle();
			if (cmd_seen != NUM_CMDS)
				report_mismatch("command_total", 64'(NUM_CMDS), 64'(cmd_seen));
			if (vertex_empty !== 1'b1)
				report_mismatch("final_vertex_empty", 64'd1, 64'(vertex_empty));
		end

		$display("summary: %0d commands, %0d jobs, %0d mismatches, %0d other errors",
			cmd_seen, jobs_seen, mismatches, failures);
		if (mismatches == 0 && failures == 0 && !timed_out) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- tb_memory_model.sv
// Testbench memory that answers queued read commands with tagged lines after random delays
`timescale 1ns/1ps
`default_nettype none

module tb_memory_model import vertex_pkg::*; #(
	parameter int NUM_WORDS = 128
) (
	input  logic                      clock,
	input  logic                      rstn,
	input  logic                      cmd_valid,
	input  logic [ADDR_BITS-1:0]      cmd_addr,
	input  array_t                    cmd_array,
	input  logic [COUNT_BITS-1:0]     cmd_count,
	input  logic [ADDR_BITS-1:0]      in_base,
	input  logic [ADDR_BITS-1:0]      out_base,
	input  logic [ADDR_BITS-1:0]      edges_base,
	input  logic [VERTEX_BITS-1:0]    in_words [NUM_WORDS],
	input  logic [VERTEX_BITS-1:0]    out_words [NUM_WORDS],
	input  logic [VERTEX_BITS-1:0]    edges_words [NUM_WORDS],
	output logic                      cmd_alfull,
	output logic                      data_valid,
	output array_t                    data_array,
	output logic [COUNT_BITS-1:0]     data_count,
	output logic [CACHELINE_BITS-1:0] data_line
);

	logic [ADDR_BITS-1:0]  addr_q [$];
	array_t                array_q [$];
	logic [COUNT_BITS-1:0] count_q [$];
	logic [ADDR_BITS-1:0]  batch_addr [3];
	array_t                batch_array [3];
	logic [COUNT_BITS-1:0] batch_count [3];
	int                    order [3];
	int                    sent;
	int                    delay;
	int                    pick;
	int                    held;
	logic                  busy;

	// One line of words starting at the command address
	function automatic logic [CACHELINE_BITS-1:0] read_line(input array_t arr,
		input logic [ADDR_BITS-1:0] addr);
		logic [CACHELINE_BITS-1:0] line;
		logic [ADDR_BITS-1:0]      offset;
		int                        idx;
		line = '0;
		case (arr)
			IN_DEGREE:  offset = addr - in_base;
			OUT_DEGREE: offset = addr - out_base;
			default:    offset = addr - edges_base;
		endcase
		for (int k = 0; k < LINE_VERTICES; k++) begin
			idx = int'(((offset >> 2) + ADDR_BITS'(k)) % ADDR_BITS'(NUM_WORDS));
			case (arr)
				IN_DEGREE:  line[k*VERTEX_BITS +: VERTEX_BITS] = in_words[idx];
				OUT_DEGREE: line[k*VERTEX_BITS +: VERTEX_BITS] = out_words[idx];
				default:    line[k*VERTEX_BITS +: VERTEX_BITS] = edges_words[idx];
			endcase
		end
		return line;
	endfunction

	initial begin
		cmd_alfull = 1'b0;
		data_valid = 1'b0;
		data_array = IN_DEGREE;
		data_count = '0;
		data_line  = '0;
		busy       = 1'b0;
		sent       = 0;
		delay      = 0;
	end

	//////////////////////////////
	// Command capture and replies
	//////////////////////////////
	always begin
		@(posedge clock);
		#1;
		// Back-pressure about one cycle in five
		cmd_alfull = ($urandom_range(4, 0) == 0);
		data_valid = 1'b0;
		if (rstn && cmd_valid) begin
			addr_q.push_back(cmd_addr);
			array_q.push_back(cmd_array);
			count_q.push_back(cmd_count);
		end
		if (!busy && addr_q.size() >= 3) begin
			for (int j = 0; j < 3; j++) begin
				batch_addr[j]  = addr_q.pop_front();
				batch_array[j] = array_q.pop_front();
				batch_count[j] = count_q.pop_front();
				order[j]       = j;
			end
			// Shuffle the return order of the batch
			for (int j = 2; j > 0; j--) begin
				pick        = $urandom_range(j, 0);
				held        = order[j];
				order[j]    = order[pick];
				order[pick] = held;
			end
			sent  = 0;
			delay = $urandom_range(10, 2);
			busy  = 1'b1;
		end else if (busy) begin
			if (delay > 1) begin
				delay = delay - 1;
			end else begin
				data_valid = 1'b1;
				data_array = batch_array[order[sent]];
				data_count = batch_count[order[sent]];
				data_line  = read_line(batch_array[order[sent]], batch_addr[order[sent]]);
				sent       = sent + 1;
				delay      = $urandom_range(10, 2);
				if (sent == 3)
					busy = 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

//--- vertex_job_control.sv
// Top level of the vertex job controller: sequencer, line buffer, command queue and job queue
`timescale 1ns/1ps
`default_nettype none

module vertex_job_control import vertex_pkg::*; #(
	parameter int JOB_FIFO_DEPTH = 64,
	parameter int CMD_FIFO_DEPTH = 16
) (
	input  logic                      clock,
	input  logic                      rstn,
	input  logic                      wed_valid,
	input  logic [VERTEX_BITS-1:0]    wed_num_vertices,
	input  logic [ADDR_BITS-1:0]      wed_in_degree_addr,
	input  logic [ADDR_BITS-1:0]      wed_out_degree_addr,
	input  logic [ADDR_BITS-1:0]      wed_edges_idx_addr,
	output logic                      cmd_valid,
	output logic [ADDR_BITS-1:0]      cmd_addr,
	output array_t                    cmd_array,
	output logic [COUNT_BITS-1:0]     cmd_count,
	input  logic                      cmd_alfull,
	input  logic                      data_valid,
	input  array_t                    data_array,
	input  logic [COUNT_BITS-1:0]     data_count,
	input  logic [CACHELINE_BITS-1:0] data_line,
	input  logic                      vertex_request,
	output logic                      vertex_valid,
	output logic [VERTEX_BITS-1:0]    vertex_id,
	output logic [VERTEX_BITS-1:0]    vertex_in_degree,
	output logic [VERTEX_BITS-1:0]    vertex_out_degree,
	output logic [VERTEX_BITS-1:0]    vertex_edges_idx,
	output logic                      vertex_empty,
	output logic [VERTEX_BITS-1:0]    vertex_job_counter,
	output logic [VERTEX_BITS-1:0]    edge_job_counter
);

	localparam int CMD_BITS = ADDR_BITS + 2 + COUNT_BITS;
	localparam int JOB_BITS = 4 * VERTEX_BITS;

	logic                  seq_cmd_push;
	logic [ADDR_BITS-1:0]  seq_cmd_addr;
	array_t                seq_cmd_array;
	logic [COUNT_BITS-1:0] seq_cmd_count;
	logic                  cmd_empty;
	logic                  cmd_pop;
	logic [CMD_BITS-1:0]   cmd_word;
	logic [1:0]            cmd_array_bits;
	logic                  lines_ready;
	logic                  unload_start;
	logic                  unload_done;
	logic                  job_push;
	logic [JOB_BITS-1:0]   job_data;
	logic [JOB_BITS-1:0]   job_word;
	logic                  job_alfull;

	vertex_read_sequencer u_sequencer (
		.clock(clock), .rstn(rstn),
		.wed_valid(wed_valid), .wed_num_vertices(wed_num_vertices),
		.wed_in_degree_addr(wed_in_degree_addr), .wed_out_degree_addr(wed_out_degree_addr),
		.wed_edges_idx_addr(wed_edges_idx_addr),
		.cmd_empty(cmd_empty), .job_alfull(job_alfull),
		.lines_ready(lines_ready), .unload_done(unload_done),
		.seq_cmd_push(seq_cmd_push), .seq_cmd_addr(seq_cmd_addr),
		.seq_cmd_array(seq_cmd_array), .seq_cmd_count(seq_cmd_count),
		.unload_start(unload_start)
	);

	vertex_line_buffer u_line_buffer (
		.clock(clock), .rstn(rstn),
		.data_valid(data_valid), .data_array(data_array),
		.data_count(data_count), .data_line(data_line),
		.unload_start(unload_start), .lines_ready(lines_ready), .unload_done(unload_done),
		.job_push(job_push), .job_data(job_data),
		.vertex_job_counter(vertex_job_counter), .edge_job_counter(edge_job_counter)
	);

	//////////////////////////////
	// Command queue
	//////////////////////////////
	assign cmd_pop = !cmd_empty && !cmd_alfull;

	sync_fifo #(.WIDTH(CMD_BITS), .DEPTH(CMD_FIFO_DEPTH), .ALFULL_MARGIN(3)) u_cmd_fifo (
		.clock(clock), .rstn(rstn),
		.push(seq_cmd_push), .data_in({seq_cmd_addr, seq_cmd_array, seq_cmd_count}),
		.pop(cmd_pop), .data_out(cmd_word), .valid(cmd_valid),
		.empty(cmd_empty), .alfull()
	);

	assign {cmd_addr, cmd_array_bits, cmd_count} = cmd_word;
	assign cmd_array = array_t'(cmd_array_bits);

	//////////////////////////////
	// Job queue
	//////////////////////////////
	sync_fifo #(.WIDTH(JOB_BITS), .DEPTH(JOB_FIFO_DEPTH), .ALFULL_MARGIN(LINE_VERTICES)) u_job_fifo (
		.clock(clock), .rstn(rstn),
		.push(job_push), .data_in(job_data),
		.pop(vertex_request), .data_out(job_word), .valid(vertex_valid),
		.empty(vertex_empty), .alfull(job_alfull)
	);

	assign {vertex_id, vertex_in_degree, vertex_out_degree, vertex_edges_idx} = job_word;

endmodule

`default_nettype wire

//--- vertex_line_buffer.sv
// Holds the three returned array lines and unloads them as one vertex job per cycle, with counters
`timescale 1ns/1ps
`default_nettype none

module vertex_line_buffer import vertex_pkg::*; (
	input  logic                     clock,
	input  logic                     rstn,
	input  logic                     data_valid,
	input  array_t                   data_array,
	input  logic [COUNT_BITS-1:0]    data_count,
	input  logic [CACHELINE_BITS-1:0] data_line,
	input  logic                     unload_start,
	output logic                     lines_ready,
	output logic                     unload_done,
	output logic                     job_push,
	output logic [4*VERTEX_BITS-1:0] job_data,
	output logic [VERTEX_BITS-1:0]   vertex_job_counter,
	output logic [VERTEX_BITS-1:0]   edge_job_counter
);

	logic [CACHELINE_BITS-1:0] line_in_degree;
	logic [CACHELINE_BITS-1:0] line_out_degree;
	logic [CACHELINE_BITS-1:0] line_edges_idx;
	logic [2:0]                arrived;
	logic [COUNT_BITS-1:0]     shift_limit;
	logic [COUNT_BITS-1:0]     shift_count;
	logic                      unloading;
	logic                      last_shift;
	logic [VERTEX_BITS-1:0]    id_counter;

	assign lines_ready = &arrived;
	assign last_shift  = (shift_count == shift_limit - 1'b1);

	//////////////////////////////
	// Line capture and shifting
	//////////////////////////////
	always_ff @(posedge clock) begin
		if (data_valid) begin
			case (data_array)
				IN_DEGREE:  line_in_degree  <= data_line;
				OUT_DEGREE: line_out_degree <= data_line;
				default:    line_edges_idx  <= data_line;
			endcase
		end else if (unloading) begin
			// Next vertex drops into the low word
			line_in_degree  <= line_in_degree >> VERTEX_BITS;
			line_out_degree <= line_out_degree >> VERTEX_BITS;
			line_edges_idx  <= line_edges_idx >> VERTEX_BITS;
		end
		if (unloading) begin
			job_data <= {id_counter,
				swap_bytes(line_in_degree[VERTEX_BITS-1:0]),
				swap_bytes(line_out_degree[VERTEX_BITS-1:0]),
				swap_bytes(line_edges_idx[VERTEX_BITS-1:0])};
		end
	end

	//////////////////////////////
	// Arrival and unload control
	//////////////////////////////
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			arrived     <= '0;
			shift_limit <= '0;
			shift_count <= '0;
			unloading   <= 1'b0;
			unload_done <= 1'b0;
			job_push    <= 1'b0;
			id_counter  <= '0;
		end else begin
			unload_done <= 1'b0;
			job_push    <= unloading;
			if (data_valid) begin
				shift_limit <= data_count;
				case (data_array)
					IN_DEGREE:  arrived[0] <= 1'b1;
					OUT_DEGREE: arrived[1] <= 1'b1;
					default:    arrived[2] <= 1'b1;
				endcase
			end
			if (unload_start) begin
				unloading   <= 1'b1;
				shift_count <= '0;
			end else if (unloading) begin
				shift_count <= shift_count + 1'b1;
				id_counter  <= id_counter + 1'b1;
				if (last_shift) begin
					unloading   <= 1'b0;
					unload_done <= 1'b1;
					arrived     <= '0;
				end
			end
		end
	end

	// Job and out-degree totals
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			vertex_job_counter <= '0;
			edge_job_counter   <= '0;
		end else if (job_push) begin
			vertex_job_counter <= vertex_job_counter + 1'b1;
			edge_job_counter   <= edge_job_counter + job_data[2*VERTEX_BITS-1:VERTEX_BITS];
		end
	end

	// Memory must not return a line while the previous one is being unloaded
	a_no_data_in_unload : assert property (@(posedge clock) disable iff (!rstn)
		data_valid |-> !unloading);

endmodule

`default_nettype wire

//--- vertex_read_sequencer.sv
// FSM that walks the vertex arrays line by line, queues three reads per line and paces unloading
`timescale 1ns/1ps
`default_nettype none

module vertex_read_sequencer import vertex_pkg::*; (
	input  logic                   clock,
	input  logic                   rstn,
	input  logic                   wed_valid,
	input  logic [VERTEX_BITS-1:0] wed_num_vertices,
	input  logic [ADDR_BITS-1:0]   wed_in_degree_addr,
	input  logic [ADDR_BITS-1:0]   wed_out_degree_addr,
	input  logic [ADDR_BITS-1:0]   wed_edges_idx_addr,
	input  logic                   cmd_empty,
	input  logic                   job_alfull,
	input  logic                   lines_ready,
	input  logic                   unload_done,
	output logic                   seq_cmd_push,
	output logic [ADDR_BITS-1:0]   seq_cmd_addr,
	output array_t                 seq_cmd_array,
	output logic [COUNT_BITS-1:0]  seq_cmd_count,
	output logic                   unload_start
);

	seq_state_t             state;
	seq_state_t             next_state;
	logic [VERTEX_BITS-1:0] remaining;
	logic [ADDR_BITS-1:0]   line_offset;
	logic [COUNT_BITS-1:0]  line_count;
	array_t                 cur_array;
	logic [ADDR_BITS-1:0]   base_addr;
	logic                   start_line;

	// Room for a full line of jobs and no reads still queued
	assign start_line = cmd_empty && !job_alfull;

	//////////////////////////////
	// Next state
	//////////////////////////////
	always_comb begin
		next_state = state;
		case (state)
			S_IDLE:       if (wed_valid) next_state = S_LOAD;
			S_LOAD:       next_state = S_WAIT_ROOM;
			S_WAIT_ROOM: begin
				if (remaining == '0)
					next_state = S_DONE;
				else if (start_line)
					next_state = S_ISSUE;
			end
			S_ISSUE:      if (cur_array == EDGES_IDX) next_state = S_WAIT_LINES;
			S_WAIT_LINES: if (lines_ready) next_state = S_UNLOAD;
			S_UNLOAD: begin
				if (unload_done)
					next_state = (remaining == '0) ? S_DONE : S_WAIT_ROOM;
			end
			S_DONE:       if (!wed_valid) next_state = S_IDLE;
			default:      next_state = S_IDLE;
		endcase
	end

	//////////////////////////////
	// Line bookkeeping
	//////////////////////////////
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state        <= S_IDLE;
			remaining    <= '0;
			line_offset  <= '0;
			line_count   <= '0;
			cur_array    <= IN_DEGREE;
			unload_start <= 1'b0;
		end else begin
			state        <= next_state;
			unload_start <= (state == S_WAIT_LINES) && lines_ready;
			case (state)
				S_LOAD: begin
					remaining   <= wed_num_vertices;
					line_offset <= '0;
				end
				S_WAIT_ROOM: begin
					cur_array <= IN_DEGREE;
					// Last line may be short
					if (remaining > VERTEX_BITS'(LINE_VERTICES))
						line_count <= COUNT_BITS'(LINE_VERTICES);
					else
						line_count <= remaining[COUNT_BITS-1:0];
				end
				S_ISSUE: begin
					case (cur_array)
						IN_DEGREE:  cur_array <= OUT_DEGREE;
						OUT_DEGREE: cur_array <= EDGES_IDX;
						default: begin
							remaining   <= remaining - VERTEX_BITS'(line_count);
							line_offset <= line_offset + ADDR_BITS'(CACHELINE_BYTES);
						end
					endcase
				end
				default: ;
			endcase
		end
	end

	always_comb begin
		case (cur_array)
			IN_DEGREE:  base_addr = wed_in_degree_addr;
			OUT_DEGREE: base_addr = wed_out_degree_addr;
			default:    base_addr = wed_edges_idx_addr;
		endcase
	end

	assign seq_cmd_push  = (state == S_ISSUE);
	assign seq_cmd_addr  = base_addr + line_offset;
	assign seq_cmd_array = cur_array;
	assign seq_cmd_count = line_count;

	// Unload only with all three lines captured by the line buffer
	a_unload_ready : assert property (@(posedge clock) disable iff (!rstn)
		unload_start |-> lines_ready);

endmodule

`default_nettype wire

//--- sync_fifo.sv
// Synchronous FIFO with registered read port and almost-full margin, used for command and job queues
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
	parameter int WIDTH         = 32,
	parameter int DEPTH         = 16,
	parameter int ALFULL_MARGIN = 1
) (
	input  logic             clock,
	input  logic             rstn,
	input  logic             push,
	input  logic [WIDTH-1:0] data_in,
	input  logic             pop,
	output logic [WIDTH-1:0] data_out,
	output logic             valid,
	output logic             empty,
	output logic             alfull
);

	localparam int PTR_BITS = $clog2(DEPTH);
	localparam int CNT_BITS = $clog2(DEPTH + 1);

	logic [WIDTH-1:0]    mem [DEPTH];
	logic [PTR_BITS-1:0] wr_ptr;
	logic [PTR_BITS-1:0] rd_ptr;
	logic [CNT_BITS-1:0] count;
	logic                full;
	logic                do_pop;

	assign empty  = (count == '0);
	assign full   = (count == CNT_BITS'(DEPTH));
	assign alfull = (CNT_BITS'(DEPTH) - count) < CNT_BITS'(ALFULL_MARGIN);
	assign do_pop = pop && !empty;

	always_ff @(posedge clock) begin
		if (push)
			mem[wr_ptr] <= data_in;
		if (do_pop)
			data_out <= mem[rd_ptr];
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
			valid  <= 1'b0;
		end else begin
			valid <= do_pop;
			if (push)
				wr_ptr <= (wr_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			case ({push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	a_no_overflow : assert property (@(posedge clock) disable iff (!rstn) !(push && full));
	a_no_underflow : assert property (@(posedge clock) disable iff (!rstn) !(pop && empty));

endmodule

`default_nettype wire

//--- vertex_pkg.sv
// Shared widths, array tags, sequencer states and byte-swap helper for the vertex job controller
`default_nettype none

package vertex_pkg;

	// Vertex and cache line geometry
	localparam int VERTEX_BITS     = 32;
	localparam int CACHELINE_BYTES = 128;
	localparam int CACHELINE_BITS  = CACHELINE_BYTES * 8;
	localparam int LINE_VERTICES   = CACHELINE_BITS / VERTEX_BITS;
	localparam int COUNT_BITS      = $clog2(LINE_VERTICES + 1);
	localparam int ADDR_BITS       = 64;

	// Tag carried by every read command and returned line
	typedef enum logic [1:0] {
		IN_DEGREE  = 2'd0,
		OUT_DEGREE = 2'd1,
		EDGES_IDX  = 2'd2
	} array_t;

	typedef enum logic [2:0] {
		S_IDLE       = 3'd0,
		S_LOAD       = 3'd1,
		S_WAIT_ROOM  = 3'd2,
		S_ISSUE      = 3'd3,
		S_WAIT_LINES = 3'd4,
		S_UNLOAD     = 3'd5,
		S_DONE       = 3'd6
	} seq_state_t;

	// Memory words come in the other byte order
	function automatic logic [VERTEX_BITS-1:0] swap_bytes(input logic [VERTEX_BITS-1:0] word);
		logic [VERTEX_BITS-1:0] swapped;
		swapped = {word[7:0], word[15:8], word[23:16], word[31:24]};
		return swapped;
	endfunction

endpackage

`default_nettype wire
